//--- flist.f
+incdir+rtl
rtl/fc_bus_pkg.sv
rtl/fc_evt_pkg.sv
rtl/fc_evt_regs.sv
rtl/fc_evt_capture.sv
rtl/fc_irq_select.sv
rtl/fc_irq_dispatch.sv
rtl/fc_subsystem.sv
bench/tb_fc_subsystem.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_fc_subsystem
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_fc_subsystem.sv
// ******************************
// fc event subsystem testbench
// table driven directed steps, a
// core model and a random phase
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module tb_fc_subsystem;

    localparam int RST_CYCLES  = 16;
    localparam int N_RAND      = 20;
    localparam int REQ_TIMEOUT = 20;

    // pin selectors for pin checks
    localparam logic [7:0] PIN_CLKEN = 8'd0;
    localparam logic [7:0] PIN_REQ   = 8'd1;

    typedef enum logic [2:0] {
        K_WR,
        K_RD,
        K_EVT,
        K_FIFO,
        K_IRQ,
        K_PIN,
        K_FETCH
    } kind_e;

    // one table entry, names kept apart
    typedef struct packed {
        kind_e        kind;
        logic [7:0]   addr;
        logic [31:0]  data;
        logic [31:0]  exp;
    } step_t;

    logic                   clk_i = 1'b0;
    logic                   arst_n_i = 1'b0;
    logic                   fetch_en_i;
    logic                   cfg_valid_i;
    fc_bus_pkg::cfg_req_t   cfg_req_i;
    logic                   cfg_rvalid_o;
    fc_bus_pkg::cfg_rsp_t   cfg_rsp_o;
    logic [31:0]            events_i;
    logic                   event_fifo_valid_i;
    logic [7:0]             event_fifo_data_i;
    logic                   irq_req_o;
    logic [4:0]             irq_id_o;
    logic                   irq_ack_i;
    logic [4:0]             irq_ack_id_i;
    logic                   core_clock_en_o;
    logic                   fetch_en_o;

    step_t        steps[$];
    string        names[$];
    // reference model state
    logic [31:0]  model_pend;
    logic [31:0]  model_mask;
    integer       seed = 71000;

    always #5 clk_i = ~clk_i;

    fc_subsystem i_dut (
        .clk_i              ( clk_i              ),
        .arst_n_i           ( arst_n_i           ),
        .fetch_en_i         ( fetch_en_i         ),
        .cfg_valid_i        ( cfg_valid_i        ),
        .cfg_req_i          ( cfg_req_i          ),
        .cfg_rvalid_o       ( cfg_rvalid_o       ),
        .cfg_rsp_o          ( cfg_rsp_o          ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .irq_req_o          ( irq_req_o          ),
        .irq_id_o           ( irq_id_o           ),
        .irq_ack_i          ( irq_ack_i          ),
        .irq_ack_id_i       ( irq_ack_id_i       ),
        .core_clock_en_o    ( core_clock_en_o    ),
        .fetch_en_o         ( fetch_en_o         )
    );

    // ******************************
    // reporting and reference model
    // ******************************
    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act)
            abort_run($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    endtask

    // highest unmasked pending line, -1 when none
    function automatic int predict_id(logic [31:0] pend, logic [31:0] mask);
        int id;
        id = -1;
        for (int i = 31; i >= 0; i--) begin
            if (pend[i] && mask[i] && id < 0)
                id = i;
        end
        return id;
    endfunction

    // ******************************
    // bus, event and core tasks
    // ******************************
    task automatic cfg_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk_i);
        cfg_valid_i     <= 1'b1;
        cfg_req_i.we    <= 1'b1;
        cfg_req_i.addr  <= addr;
        cfg_req_i.wdata <= data;
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;
        case (addr)
            `FC_REG_MASK:    model_mask = data;
            `FC_REG_PENDING: model_pend = model_pend | data;
            `FC_REG_CLEAR:   model_pend = model_pend & ~data;
            default: ;
        endcase
    endtask

    task automatic cfg_read(logic [7:0] addr, logic [31:0] exp, string name);
        @(posedge clk_i);
        cfg_valid_i     <= 1'b1;
        cfg_req_i.we    <= 1'b0;
        cfg_req_i.addr  <= addr;
        cfg_req_i.wdata <= '0;
        @(posedge clk_i);
        cfg_valid_i <= 1'b0;
        // response registered at the sampling edge
        @(negedge clk_i);
        if (!cfg_rvalid_o)
            abort_run($sformatf("no read response for %s", name));
        compare_value(name, exp, cfg_rsp_o.rdata);
    endtask

    task automatic pulse_events(logic [31:0] vec);
        @(posedge clk_i);
        events_i <= vec;
        @(posedge clk_i);
        events_i <= '0;
        model_pend = model_pend | vec;
    endtask

    task automatic fifo_strobe(logic [7:0] data);
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b1;
        event_fifo_data_i  <= data;
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b0;
        model_pend[`FC_FIFO_EVT_LINE] = 1'b1;
    endtask

    // core model, takes one interrupt
    task automatic serve_irq(logic [4:0] exp_id, string name);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!irq_req_o) begin
            if (waited == REQ_TIMEOUT)
                abort_run($sformatf("no interrupt request for %s within %0d cycles",
                                    name, REQ_TIMEOUT));
            waited++;
            @(negedge clk_i);
        end
        compare_value(name, 32'(exp_id), 32'(irq_id_o));
        // core must be running when the request is seen
        compare_value({name, " clock enable"}, 32'd1, 32'(core_clock_en_o));
        @(posedge clk_i);
        irq_ack_i    <= 1'b1;
        irq_ack_id_i <= exp_id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        model_pend[exp_id] = 1'b0;
    endtask

    task automatic check_pin(logic [7:0] pin, int cycles, logic exp, string name);
        repeat (cycles) @(posedge clk_i);
        @(negedge clk_i);
        if (pin == PIN_CLKEN)
            compare_value(name, 32'(exp), 32'(core_clock_en_o));
        else
            compare_value(name, 32'(exp), 32'(irq_req_o));
    endtask

    task automatic check_fetch(logic pad, logic exp, string name);
        @(posedge clk_i);
        fetch_en_i <= pad;
        @(negedge clk_i);
        compare_value(name, 32'(exp), 32'(fetch_en_o));
    endtask

    // ******************************
    // stimulus table
    // ******************************
    function automatic void add_step(kind_e k, logic [7:0] a, logic [31:0] d,
                                     logic [31:0] e, string n);
        step_t s;
        s.kind = k;
        s.addr = a;
        s.data = d;
        s.exp  = e;
        steps.push_back(s);
        names.push_back(n);
    endfunction

    function automatic void build_table();
        // reset values and fetch enable
        add_step(K_PIN,   PIN_CLKEN, 32'd0, 32'd1, "reset clock enable");
        add_step(K_PIN,   PIN_REQ,   32'd0, 32'd0, "reset request");
        add_step(K_RD,    `FC_REG_MASK, 32'd0, 32'd0, "reset mask");
        add_step(K_FETCH, 8'd0, 32'd0, 32'd0, "reset fetch");
        add_step(K_FETCH, 8'd0, 32'd1, 32'd0, "fetch pad only");
        add_step(K_WR,    `FC_REG_FETCH, 32'd1, 32'd0, "fetch write");
        add_step(K_FETCH, 8'd0, 32'd1, 32'd1, "fetch pad high");
        add_step(K_FETCH, 8'd0, 32'd0, 32'd0, "fetch pad low");
        // masked event, then unmask
        add_step(K_EVT,   8'd0, 32'h0000_0020, 32'd0, "event line 5");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'h0000_0020, "pending masked 5");
        add_step(K_PIN,   PIN_REQ, 32'd4, 32'd0, "masked no request");
        add_step(K_WR,    `FC_REG_MASK, 32'h0000_0020, 32'd0, "unmask 5");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd5, "irq line 5");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'd0, "pending after 5");
        // software set
        add_step(K_WR,    `FC_REG_PENDING, 32'h0000_1000, 32'd0, "software set 12");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'h0000_1000, "pending set 12");
        add_step(K_WR,    `FC_REG_MASK, 32'h0000_1020, 32'd0, "unmask 12");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd12, "irq line 12");
        // priority order 17, 9, 3
        add_step(K_EVT,   8'd0, 32'h0002_0208, 32'd0, "events 3 9 17");
        add_step(K_WR,    `FC_REG_MASK, 32'h0002_0208, 32'd0, "unmask 3 9 17");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd17, "irq line 17");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'h0000_0208, "pending after 17");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd9, "irq line 9");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'h0000_0008, "pending after 9");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd3, "irq line 3");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'd0, "pending after 3");
        // clear before service
        add_step(K_WR,    `FC_REG_MASK, 32'd0, 32'd0, "mask all");
        add_step(K_EVT,   8'd0, 32'h0040_0000, 32'd0, "event line 22");
        add_step(K_WR,    `FC_REG_CLEAR, 32'h0040_0000, 32'd0, "clear 22");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'd0, "pending cleared 22");
        add_step(K_WR,    `FC_REG_MASK, 32'h0040_0000, 32'd0, "unmask 22");
        add_step(K_PIN,   PIN_REQ, 32'd4, 32'd0, "cleared no request");
        // event fifo
        add_step(K_FIFO,  8'd0, 32'h0000_00A5, 32'd0, "fifo strobe");
        add_step(K_RD,    `FC_REG_FIFO_ID, 32'd0, 32'h0000_00A5, "fifo id");
        add_step(K_RD,    `FC_REG_PENDING, 32'd0, 32'h0400_0000, "pending fifo line");
        // sleep and wake up
        add_step(K_WR,    `FC_REG_SLEEP, 32'd1, 32'd0, "sleep");
        add_step(K_PIN,   PIN_CLKEN, 32'd2, 32'd0, "clock gated");
        add_step(K_WR,    `FC_REG_MASK, 32'h4000_0000, 32'd0, "unmask 30");
        add_step(K_PIN,   PIN_CLKEN, 32'd3, 32'd0, "still asleep");
        add_step(K_EVT,   8'd0, 32'h4000_0000, 32'd0, "event line 30");
        add_step(K_IRQ,   8'd0, 32'd0, 32'd30, "wake irq line 30");
    endfunction

    task automatic run_step(step_t st, string name);
        case (st.kind)
            K_WR:    cfg_write(st.addr, st.data);
            K_RD:    cfg_read(st.addr, st.exp, name);
            K_EVT:   pulse_events(st.data);
            K_FIFO:  fifo_strobe(st.data[7:0]);
            K_IRQ:   serve_irq(st.exp[4:0], name);
            K_PIN:   check_pin(st.addr, int'(st.data), st.exp[0], name);
            K_FETCH: check_fetch(st.data[0], st.exp[0], name);
            default: abort_run($sformatf("unknown step kind in %s", name));
        endcase
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        logic [31:0] ev;
        logic [31:0] rmask;
        int          next_id;
        string       tname;

        build_table();
        arst_n_i           = 1'b0;
        fetch_en_i         = 1'b0;
        cfg_valid_i        = 1'b0;
        cfg_req_i          = '0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        irq_ack_i          = 1'b0;
        irq_ack_id_i       = '0;
        model_pend         = '0;
        model_mask         = '0;

        repeat (RST_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;

        foreach (steps[i])
            run_step(steps[i], names[i]);

        // random events under random masks
        for (int n = 0; n < N_RAND; n++) begin
            ev = (32'd1 << ($random(seed) & 31)) | (32'd1 << ($random(seed) & 31));
            rmask = $random(seed);
            // events land while everything is masked
            cfg_write(`FC_REG_MASK, 32'd0);
            pulse_events(ev);
            cfg_write(`FC_REG_MASK, rmask);
            next_id = predict_id(model_pend, model_mask);
            while (next_id >= 0) begin
                tname = $sformatf("random %0d irq", n);
                serve_irq(next_id[4:0], tname);
                next_id = predict_id(model_pend, model_mask);
            end
        end
        cfg_read(`FC_REG_PENDING, model_pend, "random final pending");

        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog, scaled by the table and random phase length
    initial begin
        int limit;
        #1;
        limit = steps.size() * 40 + N_RAND * 60 + RST_CYCLES;
        repeat (limit) @(posedge clk_i);
        abort_run("watchdog: the run timed out without finishing");
    end

endmodule

//--- rtl/fc_subsystem.sv
// ******************************
// fc event subsystem top
// register block and the capture,
// select, dispatch pipeline
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module fc_subsystem (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         fetch_en_i,
    // configuration port
    input  logic                         cfg_valid_i,
    input  fc_bus_pkg::cfg_req_t         cfg_req_i,
    output logic                         cfg_rvalid_o,
    output fc_bus_pkg::cfg_rsp_t         cfg_rsp_o,
    // event inputs
    input  logic [`FC_NB_EVENTS-1:0]     events_i,
    input  logic                         event_fifo_valid_i,
    input  logic [`FC_FIFO_ID_W-1:0]     event_fifo_data_i,
    // core side
    output logic                         irq_req_o,
    output logic [`FC_EVT_ID_W-1:0]      irq_id_o,
    input  logic                         irq_ack_i,
    input  logic [`FC_EVT_ID_W-1:0]      irq_ack_id_i,
    output logic                         core_clock_en_o,
    output logic                         fetch_en_o
);

    fc_evt_pkg::evt_ctrl_t     evt_ctrl;
    fc_evt_pkg::irq_cand_t     irq_cand;
    fc_evt_pkg::irq_clr_t      irq_clr;
    logic [`FC_NB_EVENTS-1:0]  pending;
    logic [`FC_FIFO_ID_W-1:0]  fifo_id;

    // ******************************
    // register block
    // ******************************
    fc_evt_regs i_evt_regs (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .fetch_en_i   ( fetch_en_i   ),
        .cfg_valid_i  ( cfg_valid_i  ),
        .cfg_req_i    ( cfg_req_i    ),
        .pending_i    ( pending      ),
        .fifo_id_i    ( fifo_id      ),
        .cfg_rvalid_o ( cfg_rvalid_o ),
        .cfg_rsp_o    ( cfg_rsp_o    ),
        .ctrl_o       ( evt_ctrl     ),
        .fetch_en_o   ( fetch_en_o   )
    );

    // ******************************
    // interrupt pipeline
    // ******************************
    fc_evt_capture i_evt_capture (
        .clk_i              ( clk_i              ),
        .arst_n_i           ( arst_n_i           ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .ctrl_i             ( evt_ctrl           ),
        .clr_i              ( irq_clr            ),
        .pending_o          ( pending            ),
        .fifo_id_o          ( fifo_id            )
    );

    fc_irq_select i_irq_select (
        .clk_i    ( clk_i         ),
        .arst_n_i ( arst_n_i      ),
        .pending_i( pending       ),
        .mask_i   ( evt_ctrl.mask ),
        .cand_o   ( irq_cand      )
    );

    fc_irq_dispatch i_irq_dispatch (
        .clk_i           ( clk_i           ),
        .arst_n_i        ( arst_n_i        ),
        .cand_i          ( irq_cand        ),
        .sleep_i         ( evt_ctrl.sleep  ),
        .irq_ack_i       ( irq_ack_i       ),
        .irq_ack_id_i    ( irq_ack_id_i    ),
        .irq_req_o       ( irq_req_o       ),
        .irq_id_o        ( irq_id_o        ),
        .clr_o           ( irq_clr         ),
        .core_clock_en_o ( core_clock_en_o )
    );

endmodule

//--- rtl/fc_irq_dispatch.sv
// ******************************
// fc interrupt dispatch, stage 3
// request/acknowledge fsm towards
// the core, core clock enable
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module fc_irq_dispatch (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  fc_evt_pkg::irq_cand_t        cand_i,
    input  logic                         sleep_i,
    input  logic                         irq_ack_i,
    input  logic [`FC_EVT_ID_W-1:0]      irq_ack_id_i,
    output logic                         irq_req_o,
    output logic [`FC_EVT_ID_W-1:0]      irq_id_o,
    output fc_evt_pkg::irq_clr_t         clr_o,
    output logic                         core_clock_en_o
);

    fc_evt_pkg::disp_state_e   state_q;
    logic [1:0]                drain_cnt_q;
    logic                      raise;
    logic                      req_q;
    logic [`FC_EVT_ID_W-1:0]   id_q;
    logic                      clr_valid_q;
    logic [`FC_EVT_ID_W-1:0]   clr_id_q;
    logic                      sleep_q;
    logic                      clk_en_q;

    // new request this cycle
    assign raise = (state_q == fc_evt_pkg::DISP_IDLE) && cand_i.valid;

    // ******************************
    // fsm
    // ******************************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= fc_evt_pkg::DISP_IDLE;
            drain_cnt_q <= '0;
            req_q       <= 1'b0;
            clr_valid_q <= 1'b0;
        end else begin
            // clear strobe lasts one cycle
            clr_valid_q <= 1'b0;
            case (state_q)
                fc_evt_pkg::DISP_IDLE: begin
                    if (raise) begin
                        req_q   <= 1'b1;
                        state_q <= fc_evt_pkg::DISP_REQ;
                    end
                end
                fc_evt_pkg::DISP_REQ: begin
                    if (irq_ack_i) begin
                        req_q       <= 1'b0;
                        clr_valid_q <= 1'b1;
                        drain_cnt_q <= '0;
                        state_q     <= fc_evt_pkg::DISP_DRAIN;
                    end
                end
                fc_evt_pkg::DISP_DRAIN: begin
                    // wait until select sees the cleared bit
                    if (drain_cnt_q == 2'd2)
                        state_q <= fc_evt_pkg::DISP_IDLE;
                    else
                        drain_cnt_q <= drain_cnt_q + 2'd1;
                end
                default: state_q <= fc_evt_pkg::DISP_IDLE;
            endcase
        end
    end

    // request id and cleared id
    always_ff @(posedge clk_i) begin
        if (raise)
            id_q <= cand_i.id;
        if (state_q == fc_evt_pkg::DISP_REQ && irq_ack_i)
            clr_id_q <= irq_ack_id_i;
    end

    // ******************************
    // core clock enable
    // ******************************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sleep_q  <= 1'b0;
            clk_en_q <= 1'b1;
        end else begin
            sleep_q <= sleep_i;
            // wake up wins over a pending sleep
            if (raise)
                clk_en_q <= 1'b1;
            else if (sleep_q)
                clk_en_q <= 1'b0;
        end
    end

    assign irq_req_o       = req_q;
    assign irq_id_o        = id_q;
    assign clr_o.valid     = clr_valid_q;
    assign clr_o.id        = clr_id_q;
    assign core_clock_en_o = clk_en_q;

endmodule

//--- rtl/fc_irq_select.sv
// ******************************
// fc interrupt select, stage 2
// registered pick of the highest
// unmasked pending line
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module fc_irq_select (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [`FC_NB_EVENTS-1:0]     pending_i,
    input  logic [`FC_NB_EVENTS-1:0]     mask_i,
    output fc_evt_pkg::irq_cand_t        cand_o
);

    logic [`FC_NB_EVENTS-1:0]  masked;
    logic                      pick_valid;
    logic [`FC_EVT_ID_W-1:0]   pick_id;
    fc_evt_pkg::irq_cand_t     cand_q;

    assign masked = pending_i & mask_i;

    // ascending scan, last hit is the highest index
    always_comb begin
        pick_valid = 1'b0;
        pick_id    = '0;
        for (int i = 0; i < `FC_NB_EVENTS; i++) begin
            if (masked[i]) begin
                pick_valid = 1'b1;
                pick_id    = i[`FC_EVT_ID_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cand_q <= '0;
        end else begin
            cand_q.valid <= pick_valid;
            cand_q.id    <= pick_id;
        end
    end

    assign cand_o = cand_q;

endmodule

//--- rtl/fc_evt_capture.sv
// ******************************
// fc event capture as stage 1
// pending register and the last
// event fifo id
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module fc_evt_capture (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [`FC_NB_EVENTS-1:0]     events_i,
    input  logic                         event_fifo_valid_i,
    input  logic [`FC_FIFO_ID_W-1:0]     event_fifo_data_i,
    input  fc_evt_pkg::evt_ctrl_t        ctrl_i,
    input  fc_evt_pkg::irq_clr_t         clr_i,
    output logic [`FC_NB_EVENTS-1:0]     pending_o,
    output logic [`FC_FIFO_ID_W-1:0]     fifo_id_o
);

    logic [`FC_NB_EVENTS-1:0]  hw_set;
    logic [`FC_NB_EVENTS-1:0]  sw_set;
    logic [`FC_NB_EVENTS-1:0]  clr_vec;
    logic [`FC_NB_EVENTS-1:0]  pending_d;
    logic [`FC_NB_EVENTS-1:0]  pending_q;
    logic [`FC_FIFO_ID_W-1:0]  fifo_id_q;

    // ******************************
    // set and clear vectors
    // ******************************
    always_comb begin
        // event lines plus the fifo line
        hw_set = events_i;
        if (event_fifo_valid_i)
            hw_set[`FC_FIFO_EVT_LINE] = 1'b1;

        sw_set = ctrl_i.set_valid ? ctrl_i.set_vec : '0;

        // software clear and the acknowledged id
        clr_vec = ctrl_i.clr_valid ? ctrl_i.clr_vec : '0;
        if (clr_i.valid)
            clr_vec[clr_i.id] = 1'b1;

        // sets win over clears on the same bit
        pending_d = (pending_q & ~clr_vec) | hw_set | sw_set;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            // no fifo entry seen yet
            fifo_id_q <= '0;
        end else begin
            pending_q <= pending_d;
            if (event_fifo_valid_i)
                fifo_id_q <= event_fifo_data_i;
        end
    end

    assign pending_o = pending_q;
    assign fifo_id_o = fifo_id_q;

endmodule

//--- rtl/fc_evt_regs.sv
// ******************************
// fc event register block
// decodes configuration accesses,
// holds mask and fetch enable
// ******************************

`timescale 1ns/1ps

`include "fc_defines.svh"

module fc_evt_regs (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         fetch_en_i,
    input  logic                         cfg_valid_i,
    input  fc_bus_pkg::cfg_req_t         cfg_req_i,
    input  logic [`FC_NB_EVENTS-1:0]     pending_i,
    input  logic [`FC_FIFO_ID_W-1:0]     fifo_id_i,
    output logic                         cfg_rvalid_o,
    output fc_bus_pkg::cfg_rsp_t         cfg_rsp_o,
    output fc_evt_pkg::evt_ctrl_t        ctrl_o,
    output logic                         fetch_en_o
);

    fc_bus_pkg::reg_op_e          reg_op;
    logic                         wr_en;
    logic                         rd_en;
    logic [`FC_NB_EVENTS-1:0]     mask_q;
    logic                         fetch_q;
    logic                         rvalid_q;
    logic [`FC_CFG_DATA_W-1:0]    rdata_d;
    logic [`FC_CFG_DATA_W-1:0]    rdata_q;

    // ******************************
    // address decode
    // ******************************
    always_comb begin
        case (cfg_req_i.addr)
            `FC_REG_MASK:    reg_op = fc_bus_pkg::REG_MASK;
            `FC_REG_PENDING: reg_op = fc_bus_pkg::REG_PENDING;
            `FC_REG_CLEAR:   reg_op = fc_bus_pkg::REG_CLEAR;
            `FC_REG_FIFO_ID: reg_op = fc_bus_pkg::REG_FIFO_ID;
            `FC_REG_SLEEP:   reg_op = fc_bus_pkg::REG_SLEEP;
            `FC_REG_FETCH:   reg_op = fc_bus_pkg::REG_FETCH;
            default:         reg_op = fc_bus_pkg::REG_NONE;
        endcase
    end

    assign wr_en = cfg_valid_i & cfg_req_i.we;
    assign rd_en = cfg_valid_i & ~cfg_req_i.we;

    // mask and fetch bit, updated at the write edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q   <= '0;
            fetch_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_en && reg_op == fc_bus_pkg::REG_MASK)
                mask_q <= cfg_req_i.wdata;
            if (wr_en && reg_op == fc_bus_pkg::REG_FETCH)
                fetch_q <= cfg_req_i.wdata[0];
            // one response per read
            rvalid_q <= rd_en;
        end
    end

    // read mux, clear and sleep are write only
    always_comb begin
        rdata_d = '0;
        case (reg_op)
            fc_bus_pkg::REG_MASK:    rdata_d = mask_q;
            fc_bus_pkg::REG_PENDING: rdata_d = pending_i;
            fc_bus_pkg::REG_FIFO_ID: rdata_d[`FC_FIFO_ID_W-1:0] = fifo_id_i;
            fc_bus_pkg::REG_FETCH:   rdata_d[0] = fetch_q;
            default:                 rdata_d = '0;
        endcase
    end

    // response data
    always_ff @(posedge clk_i) begin
        if (rd_en)
            rdata_q <= rdata_d;
    end

    // ******************************
    // strobes towards the stages
    // ******************************
    assign ctrl_o.mask      = mask_q;
    assign ctrl_o.set_valid = wr_en && reg_op == fc_bus_pkg::REG_PENDING;
    assign ctrl_o.set_vec   = cfg_req_i.wdata;
    assign ctrl_o.clr_valid = wr_en && reg_op == fc_bus_pkg::REG_CLEAR;
    assign ctrl_o.clr_vec   = cfg_req_i.wdata;
    // data of a sleep write does not matter
    assign ctrl_o.sleep     = wr_en && reg_op == fc_bus_pkg::REG_SLEEP;

    assign cfg_rvalid_o    = rvalid_q;
    assign cfg_rsp_o.rdata = rdata_q;
    // both the register bit and the pad must allow fetching
    assign fetch_en_o      = fetch_q & fetch_en_i;

endmodule

//--- rtl/fc_evt_pkg.sv
// ******************************
// fc event and interrupt types
// control from the register block
// and the pipeline stage payloads
// ******************************

`include "fc_defines.svh"

package fc_evt_pkg;

    // register block to pipeline stages
    typedef struct packed {
        logic [`FC_NB_EVENTS-1:0]  mask;
        // software set, one cycle
        logic                      set_valid;
        logic [`FC_NB_EVENTS-1:0]  set_vec;
        // software clear, one cycle
        logic                      clr_valid;
        logic [`FC_NB_EVENTS-1:0]  clr_vec;
        // sleep command, one cycle
        logic                      sleep;
    } evt_ctrl_t;

    // select stage result
    typedef struct packed {
        logic                      valid;
        logic [`FC_EVT_ID_W-1:0]   id;
    } irq_cand_t;

    // dispatch back to capture after an acknowledge
    typedef struct packed {
        logic                      valid;
        logic [`FC_EVT_ID_W-1:0]   id;
    } irq_clr_t;

    // dispatch fsm
    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_REQ,
        DISP_DRAIN
    } disp_state_e;

endpackage

//--- rtl/fc_bus_pkg.sv
// ******************************
// fc configuration bus types
// request, response and the
// register selected by an access
// ******************************

`include "fc_defines.svh"

package fc_bus_pkg;

    // one access on the configuration port
    typedef struct packed {
        // 1 write, 0 read
        logic                        we;
        logic [`FC_CFG_ADDR_W-1:0]   addr;
        logic [`FC_CFG_DATA_W-1:0]   wdata;
    } cfg_req_t;

    // read data, returned one cycle after the request
    typedef struct packed {
        logic [`FC_CFG_DATA_W-1:0]   rdata;
    } cfg_rsp_t;

    // decoded register
    typedef enum logic [2:0] {
        REG_MASK,
        REG_PENDING,
        REG_CLEAR,
        REG_FIFO_ID,
        REG_SLEEP,
        REG_FETCH,
        // address outside the map
        REG_NONE
    } reg_op_e;

endpackage

//--- rtl/fc_defines.svh
// ******************************
// fc event subsystem sizes
// event count, id widths and the
// configuration register map
// ******************************

`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

// ******************************
// event and interrupt sizes
// ******************************

// number of event lines into the controller
`define FC_NB_EVENTS 32

// interrupt id width, log2 of the event count
`define FC_EVT_ID_W 5

// payload of one event fifo entry
`define FC_FIFO_ID_W 8

// pending line hit by an event fifo strobe
`define FC_FIFO_EVT_LINE 26

// ******************************
// configuration port
// ******************************

`define FC_CFG_ADDR_W 8
`define FC_CFG_DATA_W 32

// word offsets
`define FC_REG_MASK    8'h00
`define FC_REG_PENDING 8'h04
`define FC_REG_CLEAR   8'h08
`define FC_REG_FIFO_ID 8'h0C
`define FC_REG_SLEEP   8'h10
`define FC_REG_FETCH   8'h14

`endif
